// File: flist.f
hw/fm_cfg_pkg.sv
hw/fm_reg_pkg.sv
hw/fm_mmr.sv
hw/fm_param_arb.sv
hw/fm_slot_seq.sv
hw/fm_regs_top.sv
testbench/tb_fm_regs.sv

// File: hw/fm_cfg_pkg.sv
// width types shared by the FM register block, pulled in by each RTL module that needs them
package fm_cfg_pkg;

    // host side
    typedef logic [7:0] reg_addr_t;     // register address
    typedef logic [7:0] reg_data_t;     // register data byte

    // slot numbering, slot = operator * 8 + channel
    typedef logic [4:0] slot_t;         // {op, chan}
    typedef logic [2:0] chan_t;
    typedef logic [1:0] op_t;

    // parameter fields with a meaning beyond their width
    typedef logic [4:0] rate_t;         // ar, d1r, d2r
    typedef logic [6:0] level_t;        // total level, 0 is loudest

    localparam int NUM_SLOTS = 32;

endpackage

// File: hw/fm_mmr.sv
// host write port decoder, keeps the global registers and turns parameter writes into RAM requests
`timescale 1ns/1ps

module fm_mmr #(
    parameter int BUSY_CYCLES = 32
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cen,
    input  logic                             write,
    input  logic                             a0,
    input  fm_cfg_pkg::reg_data_t            din,
    output logic                             busy,
    output logic                             ne,
    output logic [4:0]                       nfrq,
    output logic [7:0]                       lfo_freq,
    output logic [1:0]                       lfo_w,
    output logic [6:0]                       lfo_amd,
    output logic [6:0]                       lfo_pmd,
    output logic                             lfo_rst,
    output logic                             ct1,
    output logic                             ct2,
    output logic [9:0]                       value_a,
    output logic [7:0]                       value_b,
    output logic                             load_a,
    output logic                             load_b,
    output logic                             irq_en_a,
    output logic                             irq_en_b,
    output logic                             clr_flag_a,
    output logic                             clr_flag_b,
    output logic [fm_cfg_pkg::NUM_SLOTS-1:0] keyon_mask,
    output logic                             wr_req,
    output fm_cfg_pkg::reg_addr_t            wr_addr,
    output fm_cfg_pkg::reg_data_t            wr_data
);

    import fm_cfg_pkg::*;
    import fm_reg_pkg::*;

    localparam int BUSY_W  = $clog2(BUSY_CYCLES + 1);
    localparam int NUM_OPS = 2 ** $bits(op_t);

    reg_addr_t         sel_addr;     // last address byte from the host
    logic              data_wr;
    logic              old_write;
    logic [BUSY_W-1:0] busy_cnt;     // cen pulses since the last data write
    chan_t             kon_ch;

    assign data_wr = write && a0;
    assign kon_ch  = din[2:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_addr   <= '0;
            ne         <= 1'b0;
            nfrq       <= '0;
            lfo_freq   <= '0;
            lfo_w      <= '0;
            lfo_amd    <= '0;
            lfo_pmd    <= '0;
            lfo_rst    <= 1'b0;
            ct1        <= 1'b0;
            ct2        <= 1'b0;
            value_a    <= '0;
            value_b    <= '0;
            load_a     <= 1'b0;
            load_b     <= 1'b0;
            irq_en_a   <= 1'b0;
            irq_en_b   <= 1'b0;
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            keyon_mask <= '0;
        end else begin
            if (write && !a0) begin
                sel_addr <= din;
            end
            if (data_wr && sel_addr < GRP_CHAN) begin
                case (sel_addr)
                    REG_LFO_RST: lfo_rst <= 1'b1;   // data byte ignored
                    REG_KON: begin
                        // din[6:3] holds one key bit per operator of the channel
                        for (int k = 0; k < NUM_OPS; k++) begin
                            keyon_mask[{op_t'(k), kon_ch}] <= din[3 + k];
                        end
                    end
                    REG_NOISE: begin
                        ne   <= din[7];
                        nfrq <= din[4:0];
                    end
                    REG_CLKA1: value_a[9:2] <= din;
                    REG_CLKA2: value_a[1:0] <= din[1:0];
                    REG_CLKB:  value_b      <= din;
                    REG_TIMER: begin
                        clr_flag_b <= din[5];
                        clr_flag_a <= din[4];
                        irq_en_b   <= din[3];
                        irq_en_a   <= din[2];
                        load_b     <= din[1];
                        load_a     <= din[0];
                    end
                    REG_LFRQ: lfo_freq <= din;
                    REG_PMDAMD: begin
                        if (din[7]) begin
                            lfo_pmd <= din[6:0];
                        end else begin
                            lfo_amd <= din[6:0];
                        end
                    end
                    REG_CTW: begin
                        ct2   <= din[7];
                        ct1   <= din[6];
                        lfo_w <= din[1:0];
                    end
                    default: ;
                endcase
            end else if (!write) begin
                lfo_rst    <= 1'b0;    // one-shot controls
                clr_flag_a <= 1'b0;
                clr_flag_b <= 1'b0;
            end
        end
    end

    // parameter bytes go to the RAM one cycle later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_req <= 1'b0;
        end else begin
            wr_req <= data_wr && (sel_addr >= GRP_CHAN);
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr) begin
            wr_addr <= sel_addr;
            wr_data <= din;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            old_write <= 1'b0;
            busy      <= 1'b0;
            busy_cnt  <= '0;
        end else begin
            old_write <= write;
            if (write && !old_write && a0) begin   // rising edge of a data write
                busy     <= 1'b1;
                busy_cnt <= '0;
            end else if (cen && busy) begin
                if (busy_cnt == BUSY_W'(BUSY_CYCLES - 1)) begin
                    busy <= 1'b0;
                end
                busy_cnt <= busy_cnt + 1'b1;
            end
        end
    end

endmodule

// File: hw/fm_param_arb.sv
// single-port parameter RAM shared by the host write path and the slot sequencer, writes first
`timescale 1ns/1ps

module fm_param_arb (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_req,
    input  fm_cfg_pkg::reg_addr_t wr_addr,
    input  fm_cfg_pkg::reg_data_t wr_data,
    input  logic                  rd_req,
    input  fm_cfg_pkg::reg_addr_t rd_addr,
    output logic                  rd_gnt,
    output logic                  rd_valid,
    output fm_cfg_pkg::reg_data_t rd_data
);

    import fm_cfg_pkg::*;

    localparam int DEPTH = 2 ** $bits(reg_addr_t);

    reg_data_t mem [DEPTH];      // 0x00-0x1f never written, global regs live in the decoder
    reg_addr_t ram_addr;

    // host writes always win, a blocked read just waits
    assign rd_gnt   = rd_req && !wr_req;
    assign ram_addr = wr_req ? wr_addr : rd_addr;

    always_ff @(posedge clk) begin
        if (wr_req) begin
            mem[ram_addr] <= wr_data;
        end else if (rd_gnt) begin
            rd_data <= mem[ram_addr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_gnt;     // data lands one cycle after the grant
        end
    end

endmodule

// File: hw/fm_reg_pkg.sv
// register address map and parameter field positions, used by the decoders and the testbench model
package fm_reg_pkg;

    // global registers, below 0x20
    localparam fm_cfg_pkg::reg_addr_t REG_LFO_RST = 8'h01;
    localparam fm_cfg_pkg::reg_addr_t REG_KON     = 8'h08;
    localparam fm_cfg_pkg::reg_addr_t REG_NOISE   = 8'h0F;
    localparam fm_cfg_pkg::reg_addr_t REG_CLKA1   = 8'h10;  // value_a[9:2]
    localparam fm_cfg_pkg::reg_addr_t REG_CLKA2   = 8'h11;  // value_a[1:0]
    localparam fm_cfg_pkg::reg_addr_t REG_CLKB    = 8'h12;
    localparam fm_cfg_pkg::reg_addr_t REG_TIMER   = 8'h14;
    localparam fm_cfg_pkg::reg_addr_t REG_LFRQ    = 8'h18;
    localparam fm_cfg_pkg::reg_addr_t REG_PMDAMD  = 8'h19;
    localparam fm_cfg_pkg::reg_addr_t REG_CTW     = 8'h1B;

    // parameter groups, channel group indexed by channel, the rest by slot
    localparam fm_cfg_pkg::reg_addr_t GRP_CHAN    = 8'h20;
    localparam fm_cfg_pkg::reg_addr_t GRP_DT1_MUL = 8'h40;
    localparam fm_cfg_pkg::reg_addr_t GRP_TL      = 8'h60;
    localparam fm_cfg_pkg::reg_addr_t GRP_KS_AR   = 8'h80;
    localparam fm_cfg_pkg::reg_addr_t GRP_AMS_D1R = 8'hA0;
    localparam fm_cfg_pkg::reg_addr_t GRP_DT2_D2R = 8'hC0;
    localparam fm_cfg_pkg::reg_addr_t GRP_D1L_RR  = 8'hE0;

    // lsb of each field within its byte
    localparam int RL_LSB    = 6;
    localparam int FB_LSB    = 3;
    localparam int CON_LSB   = 0;
    localparam int DT1_LSB   = 4;
    localparam int MUL_LSB   = 0;
    localparam int TL_LSB    = 0;
    localparam int KS_LSB    = 6;
    localparam int AR_LSB    = 0;
    localparam int AMSEN_LSB = 7;
    localparam int D1R_LSB   = 0;
    localparam int DT2_LSB   = 6;
    localparam int D2R_LSB   = 0;
    localparam int D1L_LSB   = 4;
    localparam int RR_LSB    = 0;

endpackage

// File: hw/fm_regs_top.sv
// top of the FM register block, ties the host decoder, parameter RAM and slot sequencer together
`timescale 1ns/1ps

module fm_regs_top #(
    parameter int BUSY_CYCLES = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  logic                  write,
    input  logic                  a0,
    input  fm_cfg_pkg::reg_data_t din,
    output logic                  busy,
    output logic                  ne,
    output logic [4:0]            nfrq,
    output logic [7:0]            lfo_freq,
    output logic [1:0]            lfo_w,
    output logic [6:0]            lfo_amd,
    output logic [6:0]            lfo_pmd,
    output logic                  lfo_rst,
    output logic                  ct1,
    output logic                  ct2,
    output logic [9:0]            value_a,
    output logic [7:0]            value_b,
    output logic                  load_a,
    output logic                  load_b,
    output logic                  irq_en_a,
    output logic                  irq_en_b,
    output logic                  clr_flag_a,
    output logic                  clr_flag_b,
    output logic                  slot_valid,
    output fm_cfg_pkg::slot_t     slot_idx,
    output logic [1:0]            rl,
    output logic [2:0]            fb,
    output logic [2:0]            con,
    output logic [2:0]            dt1,
    output logic [3:0]            mul,
    output fm_cfg_pkg::level_t    tl,
    output logic [1:0]            ks,
    output fm_cfg_pkg::rate_t     arate,
    output logic                  amsen,
    output fm_cfg_pkg::rate_t     rate1,
    output logic [1:0]            dt2,
    output fm_cfg_pkg::rate_t     rate2,
    output logic [3:0]            d1l,
    output logic [3:0]            rrate,
    output logic                  keyon
);

    import fm_cfg_pkg::*;

    // decoder to RAM
    logic                 wr_req;
    reg_addr_t            wr_addr;
    reg_data_t            wr_data;

    // sequencer to RAM
    logic                 rd_req;
    reg_addr_t            rd_addr;
    logic                 rd_gnt;
    logic                 rd_valid;
    reg_data_t            rd_data;

    logic [NUM_SLOTS-1:0] keyon_mask;

    fm_mmr #(
        .BUSY_CYCLES(BUSY_CYCLES)
    ) i_fm_mmr (.*);

    fm_param_arb i_fm_param_arb (.*);

    fm_slot_seq i_fm_slot_seq (.*);

endmodule

// File: hw/fm_slot_seq.sv
// slot sequencer, reads the seven parameter bytes of each slot in turn and presents them decoded
`timescale 1ns/1ps

module fm_slot_seq (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             rd_gnt,
    input  logic                             rd_valid,
    input  fm_cfg_pkg::reg_data_t            rd_data,
    input  logic [fm_cfg_pkg::NUM_SLOTS-1:0] keyon_mask,
    output logic                             rd_req,
    output fm_cfg_pkg::reg_addr_t            rd_addr,
    output logic                             slot_valid,
    output fm_cfg_pkg::slot_t                slot_idx,
    output logic [1:0]                       rl,
    output logic [2:0]                       fb,
    output logic [2:0]                       con,
    output logic [2:0]                       dt1,
    output logic [3:0]                       mul,
    output fm_cfg_pkg::level_t               tl,
    output logic [1:0]                       ks,
    output fm_cfg_pkg::rate_t                arate,
    output logic                             amsen,
    output fm_cfg_pkg::rate_t                rate1,
    output logic [1:0]                       dt2,
    output fm_cfg_pkg::rate_t                rate2,
    output logic [3:0]                       d1l,
    output logic [3:0]                       rrate,
    output logic                             keyon
);

    import fm_cfg_pkg::*;
    import fm_reg_pkg::*;

    localparam int NUM_BYTES = 7;   // channel byte plus six operator groups

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_t;

    state_t     state;
    logic [2:0] byte_idx;
    logic       last_byte;
    slot_t      slot;                   // slot being fetched
    chan_t      chan;
    reg_addr_t  grp_base;
    reg_data_t  pbyte [NUM_BYTES-1];    // bytes 0 to 5, byte 6 comes straight from rd_data

    assign chan      = slot[2:0];
    assign last_byte = (byte_idx == 3'(NUM_BYTES - 1));

    always_comb begin
        case (byte_idx)
            3'd0:    grp_base = GRP_CHAN;
            3'd1:    grp_base = GRP_DT1_MUL;
            3'd2:    grp_base = GRP_TL;
            3'd3:    grp_base = GRP_KS_AR;
            3'd4:    grp_base = GRP_AMS_D1R;
            3'd5:    grp_base = GRP_DT2_D2R;
            default: grp_base = GRP_D1L_RR;
        endcase
    end

    // held steady by the FSM while a write blocks the grant
    assign rd_req  = (state == ST_REQ);
    assign rd_addr = (byte_idx == 3'd0) ? grp_base + reg_addr_t'(chan)
                                        : grp_base + reg_addr_t'(slot);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            byte_idx   <= '0;
            slot       <= '0;
            slot_valid <= 1'b0;
        end else begin
            slot_valid <= 1'b0;
            case (state)
                ST_IDLE: state <= ST_REQ;
                ST_REQ: begin
                    if (rd_gnt) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (rd_valid) begin
                        state <= ST_REQ;
                        if (last_byte) begin
                            byte_idx   <= '0;
                            slot       <= slot + 1'b1;   // wraps after 31
                            slot_valid <= 1'b1;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WAIT && rd_valid) begin
            if (last_byte) begin
                slot_idx <= slot;
                rl       <= pbyte[0][RL_LSB +: $bits(rl)];
                fb       <= pbyte[0][FB_LSB +: $bits(fb)];
                con      <= pbyte[0][CON_LSB +: $bits(con)];
                dt1      <= pbyte[1][DT1_LSB +: $bits(dt1)];
                mul      <= pbyte[1][MUL_LSB +: $bits(mul)];
                tl       <= pbyte[2][TL_LSB +: $bits(tl)];
                ks       <= pbyte[3][KS_LSB +: $bits(ks)];
                arate    <= pbyte[3][AR_LSB +: $bits(arate)];
                amsen    <= pbyte[4][AMSEN_LSB];
                rate1    <= pbyte[4][D1R_LSB +: $bits(rate1)];
                dt2      <= pbyte[5][DT2_LSB +: $bits(dt2)];
                rate2    <= pbyte[5][D2R_LSB +: $bits(rate2)];
                d1l      <= rd_data[D1L_LSB +: $bits(d1l)];
                rrate    <= rd_data[RR_LSB +: $bits(rrate)];
                keyon    <= keyon_mask[slot];    // sampled with the last byte
            end else begin
                pbyte[byte_idx] <= rd_data;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it into sim.log and grade the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fm_regs -f flist.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?

if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status, see sim.log"
    exit 1
fi
echo "simulation passed"
exit 0

// File: testbench/tb_fm_regs.sv
// self-checking testbench for fm_regs_top, drives the host port and checks globals, busy and slots
`timescale 1ns/1ps

module tb_fm_regs;

    import fm_cfg_pkg::*;
    import fm_reg_pkg::*;

    localparam int BUSY_CYCLES = 32;
    localparam int MAX_CYCLES  = 20000;    // about 2000 needed

    logic       clk;
    logic       rst;
    logic       cen;
    logic       write;
    logic       a0;
    reg_data_t  din;
    logic       busy;
    logic       ne;
    logic [4:0] nfrq;
    logic [7:0] lfo_freq;
    logic [1:0] lfo_w;
    logic [6:0] lfo_amd;
    logic [6:0] lfo_pmd;
    logic       lfo_rst;
    logic       ct1;
    logic       ct2;
    logic [9:0] value_a;
    logic [7:0] value_b;
    logic       load_a;
    logic       load_b;
    logic       irq_en_a;
    logic       irq_en_b;
    logic       clr_flag_a;
    logic       clr_flag_b;
    logic       slot_valid;
    slot_t      slot_idx;
    logic [1:0] rl;
    logic [2:0] fb;
    logic [2:0] con;
    logic [2:0] dt1;
    logic [3:0] mul;
    level_t     tl;
    logic [1:0] ks;
    rate_t      arate;
    logic       amsen;
    rate_t      rate1;
    logic [1:0] dt2;
    rate_t      rate2;
    logic [3:0] d1l;
    logic [3:0] rrate;
    logic       keyon;

    // reference model
    logic       m_ne       = '0;
    logic [4:0] m_nfrq     = '0;
    logic [7:0] m_lfo_freq = '0;
    logic [1:0] m_lfo_w    = '0;
    logic [6:0] m_lfo_amd  = '0;
    logic [6:0] m_lfo_pmd  = '0;
    logic       m_lfo_rst  = '0;
    logic       m_ct1      = '0;
    logic       m_ct2      = '0;
    logic [9:0] m_value_a  = '0;
    logic [7:0] m_value_b  = '0;
    logic [5:0] m_timer    = '0;    // {clr_b, clr_a, irq_b, irq_a, load_b, load_a}
    logic [NUM_SLOTS-1:0] m_kon = '0;
    reg_data_t  m_ram [256];

    reg_addr_t glob_regs [10] = '{REG_LFO_RST, REG_KON, REG_NOISE, REG_CLKA1, REG_CLKA2,
                                  REG_CLKB, REG_TIMER, REG_LFRQ, REG_PMDAMD, REG_CTW};
    reg_addr_t op_groups [6] = '{GRP_DT1_MUL, GRP_TL, GRP_KS_AR, GRP_AMS_D1R,
                                 GRP_DT2_D2R, GRP_D1L_RR};

    logic [31:0] rng = 32'h86ca;
    int          cycles = 0;
    logic        slot_seen = 1'b0;
    slot_t       prev_slot;
    slot_t       next_slot;

    fm_regs_top #(
        .BUSY_CYCLES(BUSY_CYCLES)
    ) i_fm_regs_top (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cen <= ~cen;    // every other cycle
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic drive_bus(input logic w, input logic sel, input reg_data_t d);
        @(posedge clk);
        write <= w;
        a0    <= sel;
        din   <= d;
    endtask

    task automatic apply_model(input reg_addr_t addr, input reg_data_t d);
        if (addr >= GRP_CHAN) begin
            m_ram[addr] = d;
        end else begin
            case (addr)
                REG_LFO_RST: m_lfo_rst = 1'b1;
                REG_KON: begin
                    for (int k = 0; k < 4; k++) begin
                        m_kon[k * 8 + int'(d[2:0])] = d[3 + k];
                    end
                end
                REG_NOISE: begin
                    m_ne   = d[7];
                    m_nfrq = d[4:0];
                end
                REG_CLKA1:  m_value_a[9:2] = d;
                REG_CLKA2:  m_value_a[1:0] = d[1:0];
                REG_CLKB:   m_value_b = d;
                REG_TIMER:  m_timer = d[5:0];
                REG_LFRQ:   m_lfo_freq = d;
                REG_PMDAMD: begin
                    if (d[7]) begin
                        m_lfo_pmd = d[6:0];
                    end else begin
                        m_lfo_amd = d[6:0];
                    end
                end
                REG_CTW: begin
                    m_ct2   = d[7];
                    m_ct1   = d[6];
                    m_lfo_w = d[1:0];
                end
                default: ;
            endcase
        end
    endtask

    // address, gap, data, gap; the gaps give busy a fresh write edge
    task automatic write_reg(input reg_addr_t addr, input reg_data_t d);
        drive_bus(1'b1, 1'b0, addr);
        drive_bus(1'b0, 1'b0, '0);
        drive_bus(1'b1, 1'b1, d);
        drive_bus(1'b0, 1'b0, '0);
        apply_model(addr, d);
    endtask

    // every parameter byte, write held high so requests come back to back
    task automatic write_param_burst();
        reg_data_t d;
        for (int a = 32'h20; a < 256; a++) begin
            rng = xorshift(rng);
            d = rng[7:0];
            drive_bus(1'b1, 1'b0, reg_addr_t'(a));
            drive_bus(1'b1, 1'b1, d);
            apply_model(reg_addr_t'(a), d);
        end
        drive_bus(1'b0, 1'b0, '0);
    endtask

    task automatic check_globals();
        check_hex("ne", ne, m_ne);
        check_hex("nfrq", nfrq, m_nfrq);
        check_hex("lfo_freq", lfo_freq, m_lfo_freq);
        check_hex("lfo_w", lfo_w, m_lfo_w);
        check_hex("lfo_amd", lfo_amd, m_lfo_amd);
        check_hex("lfo_pmd", lfo_pmd, m_lfo_pmd);
        check_hex("lfo_rst", lfo_rst, m_lfo_rst);
        check_hex("ct1", ct1, m_ct1);
        check_hex("ct2", ct2, m_ct2);
        check_hex("value_a", value_a, m_value_a);
        check_hex("value_b", value_b, m_value_b);
        check_hex("load_a", load_a, m_timer[0]);
        check_hex("load_b", load_b, m_timer[1]);
        check_hex("irq_en_a", irq_en_a, m_timer[2]);
        check_hex("irq_en_b", irq_en_b, m_timer[3]);
        check_hex("clr_flag_a", clr_flag_a, m_timer[4]);
        check_hex("clr_flag_b", clr_flag_b, m_timer[5]);
    endtask

    task automatic count_busy(output int n);
        n = 0;
        @(negedge clk);
        check_hex("busy", busy, 1'b1);
        while (busy) begin
            if (cen) begin
                n++;    // sampled by the next edge
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_slot();
        @(negedge clk);
        while (!slot_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic check_slot();
        slot_t     s;
        reg_data_t b [7];
        s = slot_idx;
        b[0] = m_ram[GRP_CHAN + reg_addr_t'(s[2:0])];
        for (int k = 0; k < 6; k++) begin
            b[k + 1] = m_ram[op_groups[k] + reg_addr_t'(s)];
        end
        check_hex("rl", rl, b[0][RL_LSB +: 2]);
        check_hex("fb", fb, b[0][FB_LSB +: 3]);
        check_hex("con", con, b[0][CON_LSB +: 3]);
        check_hex("dt1", dt1, b[1][DT1_LSB +: 3]);
        check_hex("mul", mul, b[1][MUL_LSB +: 4]);
        check_hex("tl", tl, b[2][TL_LSB +: 7]);
        check_hex("ks", ks, b[3][KS_LSB +: 2]);
        check_hex("arate", arate, b[3][AR_LSB +: 5]);
        check_hex("amsen", amsen, b[4][AMSEN_LSB]);
        check_hex("rate1", rate1, b[4][D1R_LSB +: 5]);
        check_hex("dt2", dt2, b[5][DT2_LSB +: 2]);
        check_hex("rate2", rate2, b[5][D2R_LSB +: 5]);
        check_hex("d1l", d1l, b[6][D1L_LSB +: 4]);
        check_hex("rrate", rrate, b[6][RR_LSB +: 4]);
        check_hex("keyon", keyon, m_kon[s]);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // slots must come in order with no gaps
    always @(negedge clk) begin
        if (!rst && slot_valid) begin
            next_slot = prev_slot + 5'd1;
            if (slot_seen) begin
                check_hex("slot_idx", slot_idx, next_slot);
            end
            prev_slot = slot_idx;
            slot_seen = 1'b1;
        end
    end

    initial begin
        reg_data_t d;
        int        n;
        clk   = 1'b0;
        rst   = 1'b1;
        cen   = 1'b0;
        write = 1'b0;
        a0    = 1'b0;
        din   = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_globals();
        check_hex("busy", busy, 1'b0);
        check_hex("slot_valid", slot_valid, 1'b0);

        // globals, levels and one-cycle pulses
        for (int rep = 0; rep < 4; rep++) begin
            for (int r = 0; r < 10; r++) begin
                rng = xorshift(rng);
                d = rng[7:0];
                if (glob_regs[r] == REG_PMDAMD) begin
                    d[7] = rep[0];    // both the amd and the pmd side
                end
                write_reg(glob_regs[r], d);
                @(negedge clk);
                check_globals();
                m_lfo_rst  = 1'b0;
                m_timer[5:4] = 2'b00;
                @(negedge clk);
                check_globals();
            end
        end

        // busy timing
        while (busy) begin
            @(negedge clk);
        end
        drive_bus(1'b1, 1'b0, REG_CLKB);
        drive_bus(1'b0, 1'b0, '0);
        repeat (4) begin
            @(negedge clk);
            check_hex("busy", busy, 1'b0);
        end
        write_reg(REG_CLKB, 8'h5a);
        count_busy(n);
        check_hex("busy cen pulses", n, BUSY_CYCLES);
        write_reg(REG_CLKB, 8'ha5);
        repeat (20) @(negedge clk);
        write_reg(REG_CLKB, 8'h3c);
        count_busy(n);
        check_hex("busy cen pulses after restart", n, BUSY_CYCLES);

        // key-on masks for every channel
        for (int ch = 0; ch < 8; ch++) begin
            rng = xorshift(rng);
            d = rng[7:0];
            d[2:0] = 3'(ch);
            write_reg(REG_KON, d);
        end

        // parameter bytes while the sequencer runs, then two full rounds
        write_param_burst();
        repeat (NUM_SLOTS) wait_slot();
        repeat (NUM_SLOTS) begin
            wait_slot();
            check_slot();
        end

        $display("TEST OK");
        $finish;
    end

endmodule
